// ==== hw/regStagePkg.sv ====
`default_nettype none

package regStagePkg;

	// ============================================================
	// widths and sizes
	// ============================================================

	localparam int ctxWidth = 4;
	localparam int numWidth = 5;
	localparam int dataWidth = 64;
	// 16 contexts of 32 registers
	localparam int regCount = 512;

	// ============================================================
	// opcode classes, opcode sits in ir[31:25]
	// ============================================================

	localparam logic [6:0] opR = 7'h01;
	localparam logic [6:0] opRR = 7'h02;
	localparam logic [6:0] opMux = 7'h03;
	localparam logic [6:0] opCall = 7'h19;
	localparam logic [6:0] opJmp = 7'h1a;
	localparam logic [6:0] opRet = 7'h1b;
	localparam logic [6:0] opMemNdx = 7'h35;
	localparam logic [6:0] opNop = 7'h3a;
	localparam logic [6:0] opBranchI = 7'h48;
	localparam logic [6:0] opStore = 7'h60;
	// set-immediates decode only ir[31:27]
	// ir[26:25] already belongs to the target field
	localparam logic [6:0] opSetLo = 7'h70;
	localparam logic [6:0] opSetHi = 7'h74;
	localparam logic [6:0] opImm = 7'h7c;

	// function codes in ir[6:0] that produce no register result
	localparam logic [6:0] fnMtspr = 7'h29;
	localparam logic [6:0] fnExec = 7'h2c;
	// indexed store inside the MEMNDX class
	localparam logic [6:0] fnStoreX = 7'h13;

	// fixed targets of call and return
	localparam logic [4:0] linkReg = 5'd31;
	localparam logic [4:0] retReg = 5'd30;

	// ============================================================
	// instruction word, two decodings of the same 32 bits
	// ============================================================

	// register-register layout
	// in the R class the target lives where RR keeps rb
	typedef struct packed {
		logic [6:0] opcode;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rtRR;
		logic [2:0] spare;
		logic [6:0] func;
	} rrView;

	// register-immediate layout
	typedef struct packed {
		logic [6:0] opcode;
		logic [4:0] ra;
		logic [4:0] rt;
		logic [14:0] immediate;
	} riView;

	typedef union packed {
		rrView rr;
		riView ri;
	} instrWord;

	// context-qualified register address, all zero means no target
	typedef struct packed {
		logic [ctxWidth-1:0] ctx;
		logic [numWidth-1:0] num;
	} regAddr;

	// addresses handed to execute
	typedef struct packed {
		regAddr rt;
		regAddr ra;
		regAddr rb;
	} execRegs;

endpackage

`default_nettype wire

// ==== hw/targetRegDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module targetRegDecode (
	input wire clk,
	input wire rst,
	input wire advanceR,
	input wire advanceX,
	input wire regStagePkg::instrWord ir,
	input wire irValid,
	input wire [regStagePkg::ctxWidth-1:0] axc,
	output regStagePkg::regAddr xRt
);
	import regStagePkg::*;

	logic isSet;
	logic [numWidth-1:0] rtNum;
	regAddr dRt;

	// ============================================================
	// target field select by opcode class
	// ============================================================

	// both set-immediates share the upper five opcode bits pattern
	assign isSet = (ir.rr.opcode[6:2] == opSetLo[6:2]) ||
		(ir.rr.opcode[6:2] == opSetHi[6:2]);

	always_comb begin
		rtNum = '0;
		if (isSet) begin
			// target overlaps the low opcode bits
			rtNum = ir[26:22];
		end else begin
			case (ir.rr.opcode)
				opR: begin
					// special moves and exec write no gpr
					if (ir.rr.func == fnMtspr || ir.rr.func == fnExec)
						rtNum = '0;
					else
						rtNum = ir.ri.rt;
				end
				opRR:
					rtNum = ir.rr.rtRR;
				opMux:
					// mux carries three sources, target down in 9:5
					rtNum = ir[9:5];
				opMemNdx: begin
					// indexed loads write rtRR, indexed stores write nothing
					if (ir.rr.func == fnStoreX)
						rtNum = '0;
					else
						rtNum = ir.rr.rtRR;
				end
				opCall:
					rtNum = linkReg;
				opRet:
					rtNum = retReg;
				opStore, opBranchI, opJmp, opNop, opImm:
					rtNum = '0;
				default:
					rtNum = ir.ri.rt;
			endcase
		end
	end

	// r0 never counts as a target, so fold it to the all-zero address
	// invalid slot also gives no target
	assign dRt = (irValid && rtNum != '0) ? {axc, rtNum} : '0;

	// ============================================================
	// execute-stage target register
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			xRt <= '0;
		end else if (advanceR) begin
			xRt <= dRt;
		end else if (advanceX) begin
			// execute moves on while decode holds, so a bubble enters
			xRt <= '0;
		end
	end

	// interlock relies on r0 never appearing as a live target
	assert property (@(posedge clk) disable iff (rst)
		(xRt != '0) |-> (xRt.num != '0))
		else $error("xRt holds register 0 with a nonzero context");

endmodule

`default_nettype wire

// ==== hw/sourceRegDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module sourceRegDecode (
	input wire clk,
	input wire rst,
	input wire advanceR,
	input wire advanceX,
	input wire regStagePkg::instrWord ir,
	input wire irValid,
	input wire [regStagePkg::ctxWidth-1:0] axc,
	output regStagePkg::regAddr dRa,
	output regStagePkg::regAddr dRb,
	output regStagePkg::regAddr xRa,
	output regStagePkg::regAddr xRb
);
	import regStagePkg::*;

	logic hasRb;

	// ============================================================
	// decode-stage sources, feed the interlock directly
	// ============================================================

	// only these classes read a second register from ir[19:15]
	// elsewhere those bits are a target or immediate
	always_comb begin
		case (ir.rr.opcode)
			opRR, opMemNdx, opStore, opMux:
				hasRb = 1'b1;
			default:
				hasRb = 1'b0;
		endcase
	end

	assign dRa = irValid ? {axc, ir.rr.ra} : '0;
	assign dRb = (irValid && hasRb) ? {axc, ir.rr.rb} : '0;

	// ============================================================
	// execute-stage sources, same load and bubble rule as xRt
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			xRa <= '0;
			xRb <= '0;
		end else if (advanceR) begin
			xRa <= dRa;
			xRb <= dRb;
		end else if (advanceX) begin
			xRa <= '0;
			xRb <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/operandInterlock.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandInterlock (
	input wire advanceX,
	input wire regStagePkg::regAddr dRa,
	input wire regStagePkg::regAddr dRb,
	input wire regStagePkg::regAddr xRt,
	output logic stall,
	output logic advanceR
);
	import regStagePkg::*;

	logic xRtLive;
	logic hitA;
	logic hitB;

	// ============================================================
	// read-after-write hazard against execute
	// ============================================================

	// zero address means execute produces nothing
	assign xRtLive = (xRt != regAddr'('0));

	// a source of r0 is zero in the address too, except the context
	// those never match a live target since xRt.num is never 0 there
	assign hitA = (dRa == xRt);
	assign hitB = (dRb == xRt);

	// no forwarding path, so any hit holds decode
	assign stall = xRtLive && (hitA || hitB);

	// ============================================================
	// decode advance strobe
	// ============================================================

	// decode follows execute unless held
	// when held and execute moves, the decoders load a bubble
	assign advanceR = advanceX && !stall;

endmodule

`default_nettype wire

// ==== hw/contextRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module contextRegFile (
	input wire clk,
	input wire rst,
	input wire we,
	input wire regStagePkg::regAddr wAddr,
	input wire [regStagePkg::dataWidth-1:0] wData,
	input wire regStagePkg::regAddr rAddrA,
	input wire regStagePkg::regAddr rAddrB,
	output logic [regStagePkg::dataWidth-1:0] rDataA,
	output logic [regStagePkg::dataWidth-1:0] rDataB
);
	import regStagePkg::*;

	// ============================================================
	// storage, indexed by {context, register}
	// ============================================================

	logic [dataWidth-1:0] regs [regCount];

	// write takes effect at the edge, read sees it one cycle later
	// writes to r0 of any context are dropped
	always_ff @(posedge clk) begin
		if (we && wAddr.num != '0) begin
			regs[wAddr] <= wData;
		end
	end

	// ============================================================
	// read ports, combinational
	// ============================================================

	// r0 reads zero in every context
	assign rDataA = (rAddrA.num == '0) ? '0 : regs[rAddrA];
	assign rDataB = (rAddrB.num == '0) ? '0 : regs[rAddrB];

	// writeback must present a clean address when it writes
	assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(wAddr))
		else $error("register write with unknown address");

endmodule

`default_nettype wire

// ==== hw/regReadStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module regReadStage (
	input wire clk,
	input wire rst,
	input wire regStagePkg::instrWord ir,
	input wire irValid,
	input wire [regStagePkg::ctxWidth-1:0] axc,
	input wire advanceX,
	input wire wbEn,
	input wire regStagePkg::regAddr wbAddr,
	input wire [regStagePkg::dataWidth-1:0] wbData,
	output wire regStagePkg::execRegs xRegs,
	output wire [regStagePkg::dataWidth-1:0] xA,
	output wire [regStagePkg::dataWidth-1:0] xB,
	output wire stall
);
	import regStagePkg::*;

	// decode-stage sources for the hazard check
	wire regAddr dRa;
	wire regAddr dRb;
	// decoders load on this
	wire advanceR;

	// ============================================================
	// decoders
	// ============================================================

	targetRegDecode i_targetRegDecode (
		.clk(clk), .rst(rst),
		.advanceR(advanceR), .advanceX(advanceX),
		.ir(ir), .irValid(irValid), .axc(axc),
		.xRt(xRegs.rt)
	);

	sourceRegDecode i_sourceRegDecode (
		.clk(clk), .rst(rst),
		.advanceR(advanceR), .advanceX(advanceX),
		.ir(ir), .irValid(irValid), .axc(axc),
		.dRa(dRa), .dRb(dRb),
		.xRa(xRegs.ra), .xRb(xRegs.rb)
	);

	// ============================================================
	// hazard check and register file
	// ============================================================

	operandInterlock i_operandInterlock (
		.advanceX(advanceX),
		.dRa(dRa), .dRb(dRb), .xRt(xRegs.rt),
		.stall(stall), .advanceR(advanceR)
	);

	// operands for execute come straight off the registered sources
	contextRegFile i_contextRegFile (
		.clk(clk), .rst(rst),
		.we(wbEn), .wAddr(wbAddr), .wData(wbData),
		.rAddrA(xRegs.ra), .rAddrB(xRegs.rb),
		.rDataA(xA), .rDataB(xB)
	);

endmodule

`default_nettype wire

// ==== sim/regReadStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module regReadStageTb;
	import regStagePkg::*;

	logic clk;
	logic rst;
	instrWord ir;
	logic irValid;
	logic [ctxWidth-1:0] axc;
	logic advanceX;
	logic wbEn;
	regAddr wbAddr;
	logic [dataWidth-1:0] wbData;
	wire execRegs xRegs;
	wire [dataWidth-1:0] xA;
	wire [dataWidth-1:0] xB;
	wire stall;

	// 13 words per vector, kept in file column order
	logic [63:0] words[$];
	int numVectors;
	int errors;
	bit loaded;

	regReadStage i_regReadStage (
		.clk(clk), .rst(rst), .ir(ir), .irValid(irValid), .axc(axc),
		.advanceX(advanceX), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
		.xRegs(xRegs), .xA(xA), .xB(xB), .stall(stall)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ============================================================
	// stimulus file and mismatch report
	// ============================================================

	task automatic loadStimulus();
		int fd;
		int count;
		string text;
		logic [63:0] f [13];
		fd = $fopen("sim/regReadStimulus.txt", "r");
		if (fd == 0) begin
			$display("stimulus file sim/regReadStimulus.txt could not be opened");
			errors++;
			return;
		end
		while ($fgets(text, fd) != 0) begin
			// column notes and blank lines carry no vector
			if (text.len() < 2 || text[0] == "#")
				continue;
			count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6],
				f[7], f[8], f[9], f[10], f[11], f[12]);
			if (count != 13) begin
				$display("stimulus vector %0d is short, %0d of 13 columns",
					numVectors + 1, count);
				errors++;
			end else begin
				foreach (f[k])
					words.push_back(f[k]);
				numVectors++;
			end
		end
		$fclose(fd);
		if (numVectors == 0) begin
			$display("stimulus file holds no vectors");
			errors++;
		end
	endtask

	task automatic reportMismatch(string name, int vec, logic [63:0] expected,
		logic [63:0] actual);
		errors++;
		$display("[FAIL] vector %0d %s expected %h actual %h", vec, name, expected, actual);
	endtask

	// ============================================================
	// drive and check, one vector per cycle
	// ============================================================

	initial begin
		int v;
		int b;
		errors = 0;
		numVectors = 0;
		loaded = 1'b0;
		rst = 1'b1;
		ir = '0;
		irValid = 1'b0;
		axc = '0;
		advanceX = 1'b0;
		wbEn = 1'b0;
		wbAddr = '0;
		wbData = '0;
		loadStimulus();
		loaded = 1'b1;
		// reset spans 8 rising edges, released on a falling edge
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (v = 0; v < numVectors; v++) begin
			b = v * 13;
			ir = words[b][31:0];
			irValid = words[b + 1][0];
			axc = words[b + 2][ctxWidth-1:0];
			advanceX = words[b + 3][0];
			wbEn = words[b + 4][0];
			wbAddr = words[b + 5][8:0];
			wbData = words[b + 6];
			// stall comes from ir and the current xRegs.rt, look before the edge
			#1;
			if (stall !== words[b + 7][0])
				reportMismatch("stall", v + 1, words[b + 7], 64'(stall));
			@(posedge clk);
			// registered addresses, operands read through them
			#1;
			if (xRegs.rt !== words[b + 8][8:0])
				reportMismatch("xRegs.rt", v + 1, words[b + 8], 64'(xRegs.rt));
			if (xRegs.ra !== words[b + 9][8:0])
				reportMismatch("xRegs.ra", v + 1, words[b + 9], 64'(xRegs.ra));
			if (xRegs.rb !== words[b + 10][8:0])
				reportMismatch("xRegs.rb", v + 1, words[b + 10], 64'(xRegs.rb));
			if (xA !== words[b + 11])
				reportMismatch("xA", v + 1, words[b + 11], xA);
			if (xB !== words[b + 12])
				reportMismatch("xB", v + 1, words[b + 12], xB);
			@(negedge clk);
		end
		$display("%0d vectors run, %0d errors", numVectors, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// reset plus one cycle per vector, with a margin of 20 cycles
	initial begin
		wait (loaded);
		#((numVectors + 8 + 20) * 10);
		$display("watchdog expired before all vectors ran");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/regReadStimulus.txt ====
# inputs: ir irValid axc advanceX wbEn wbAddr wbData
# expected: stall xRegs.rt xRegs.ra xRegs.rb xA xB (all columns hex)
04219000 0 3 1 1 062 0123456789abcdef 0 000 000 000 0000000000000000 0000000000000000
04219000 1 3 1 1 063 fedcba9876543210 0 064 062 063 0123456789abcdef fedcba9876543210
02428000 1 3 1 1 064 0000000000000044 1 000 000 000 0000000000000000 0000000000000000
02428000 1 3 1 1 0a2 00000000cafef00d 0 065 064 000 0000000000000044 0000000000000000
04511800 1 3 0 1 060 5555aaaa5555aaaa 1 065 064 000 0000000000000044 0000000000000000
04511800 1 3 1 1 065 0000000000000055 1 000 000 000 0000000000000000 0000000000000000
04511800 1 3 1 0 000 0000000000000000 0 066 065 062 0000000000000055 0123456789abcdef
c0030000 1 3 1 1 066 0000000000000066 1 000 000 000 0000000000000000 0000000000000000
c0030000 1 3 1 0 000 0000000000000000 0 000 060 066 0000000000000000 0000000000000066
02248029 1 5 1 0 000 0000000000000000 0 000 0a2 000 00000000cafef00d 0000000000000000
e2200000 1 3 1 0 000 0000000000000000 0 068 062 000 0123456789abcdef 0000000000000000
06010120 1 3 1 0 000 0000000000000000 0 069 060 062 0000000000000000 0123456789abcdef
6a21a813 1 3 1 0 000 0000000000000000 0 000 062 063 0123456789abcdef fedcba9876543210
32200000 1 3 1 0 000 0000000000000000 0 07f 062 000 0123456789abcdef 0000000000000000
36300000 1 3 1 0 000 0000000000000000 0 07e 063 000 fedcba9876543210 0000000000000000
20260000 1 3 1 0 000 0000000000000000 0 06c 062 000 0123456789abcdef 0000000000000000

// ==== list.f ====
hw/regStagePkg.sv
hw/targetRegDecode.sv
hw/sourceRegDecode.sv
hw/operandInterlock.sv
hw/contextRegFile.sv
hw/regReadStage.sv
sim/regReadStageTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = regReadStageTb
FILELIST = list.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make help   list these targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
